//--- exec_core.f
+incdir+.
isa_pkg.sv
stage_pkg.sv
stage_if.sv
inst_decoder.sv
reg_manage.sv
inst_window.sv
alu_exec.sv
exec_core.sv
tb_exec_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f exec_core.f --top-module tb_exec_core -o sim_exec_core
./obj_dir/sim_exec_core | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

//--- tb_exec_core.sv
`include "core_defs.svh"

module tb_exec_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [6:0] OPC_REG  = 7'b0110011;
    localparam logic [6:0] OPC_IMM  = 7'b0010011;
    localparam logic [6:0] OPC_UPPER = 7'b0110111;
    localparam int         TIMEOUT  = 400;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    logic [`LEN_INST-1:0]     in_inst;
    logic                     in_credit;
    logic                     wb_valid;
    logic [`LEN_REG_ADDR-1:0] wb_rd;
    logic [`LEN_WORD-1:0]     wb_data;

    // program table, per-register expected results filled by the model
    logic [31:0] prog_inst [$];
    logic [31:0] ref_regs  [32];
    logic [31:0] exp_q     [32][$];
    int          credits;
    int          credit_pulses;

    exec_core uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_inst   (in_inst),
        .in_credit (in_credit),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
            report_failure("value mismatch");
        end
    endtask

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_UPPER};
    endfunction

    // rv32i integer semantics, alt selects sub and sra
    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? ((a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0))
                                : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] model_inst(input logic [31:0] w);
        logic [31:0] imm;
        imm = {{20{w[31]}}, w[31:20]};
        case (w[6:0])
            OPC_UPPER: return {w[31:12], 12'h000};
            OPC_IMM:   return model_alu(w[14:12], w[14:12] == 3'd5 && w[30],
                                        ref_regs[w[19:15]], imm);
            default:   return model_alu(w[14:12], w[30], ref_regs[w[19:15]],
                                        ref_regs[w[24:20]]);
        endcase
    endfunction

    task automatic build_table();
        logic [31:0] res;
        prog_inst = '{
            enc_lui(20'h12345, 5'd1),
            enc_i(12'h678, 5'd1, 3'd0, 5'd1),
            enc_i(12'hffb, 5'd0, 3'd0, 5'd2),
            enc_i(12'h007, 5'd0, 3'd0, 5'd3),
            enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd4),
            enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd5),
            enc_r(7'h00, 5'd3, 5'd1, 3'd1, 5'd6),
            enc_r(7'h00, 5'd3, 5'd2, 3'd2, 5'd7),
            enc_r(7'h00, 5'd3, 5'd2, 3'd3, 5'd8),
            enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd9),
            enc_r(7'h00, 5'd3, 5'd2, 3'd5, 5'd10),
            enc_r(7'h20, 5'd3, 5'd2, 3'd5, 5'd11),
            enc_r(7'h00, 5'd3, 5'd1, 3'd6, 5'd12),
            enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd13),
            enc_i(12'hfff, 5'd2, 3'd2, 5'd14),
            enc_i(12'hfff, 5'd3, 3'd3, 5'd15),
            enc_i(12'hfff, 5'd1, 3'd4, 5'd16),
            enc_i(12'h0f0, 5'd3, 3'd6, 5'd17),
            enc_i(12'h7f0, 5'd1, 3'd7, 5'd18),
            enc_i({7'h00, 5'd28}, 5'd3, 3'd1, 5'd19),
            enc_i({7'h00, 5'd4}, 5'd2, 3'd5, 5'd20),
            enc_i({7'h20, 5'd2}, 5'd2, 3'd5, 5'd21),
            // x0 destinations, then reads of x0
            enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd0),
            enc_i(12'h07b, 5'd0, 3'd0, 5'd0),
            enc_r(7'h00, 5'd3, 5'd0, 3'd0, 5'd22),
            enc_r(7'h00, 5'd3, 5'd0, 3'd3, 5'd28),
            // dependent chain
            enc_i(12'h001, 5'd22, 3'd0, 5'd23),
            enc_r(7'h00, 5'd23, 5'd23, 3'd0, 5'd23),
            enc_r(7'h20, 5'd1, 5'd23, 3'd0, 5'd23),
            enc_r(7'h00, 5'd4, 5'd23, 3'd4, 5'd24),
            // repeated writes to one register
            enc_i(12'h001, 5'd3, 3'd0, 5'd26),
            enc_i(12'h001, 5'd26, 3'd0, 5'd26),
            enc_i(12'h064, 5'd3, 3'd0, 5'd26),
            enc_r(7'h00, 5'd26, 5'd26, 3'd0, 5'd27),
            enc_lui(20'hfffff, 5'd26),
            // serial chain with distinct destinations backs up into a full window
            enc_r(7'h00, 5'd24, 5'd24, 3'd0, 5'd25),
            enc_r(7'h00, 5'd25, 5'd25, 3'd0, 5'd29),
            enc_r(7'h00, 5'd29, 5'd29, 3'd0, 5'd30),
            enc_r(7'h00, 5'd30, 5'd30, 3'd0, 5'd31),
            enc_r(7'h00, 5'd31, 5'd31, 3'd0, 5'd5),
            enc_r(7'h00, 5'd5, 5'd5, 3'd0, 5'd6),
            enc_r(7'h00, 5'd6, 5'd6, 3'd0, 5'd7)
        };
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = 32'd0;
        end
        foreach (prog_inst[i]) begin
            res = model_inst(prog_inst[i]);
            if (prog_inst[i][11:7] != 5'd0) begin
                ref_regs[prog_inst[i][11:7]] = res;
                exp_q[prog_inst[i][11:7]].push_back(res);
            end
        end
    endtask

    function automatic bit queues_empty();
        for (int r = 0; r < 32; r++) begin
            if (exp_q[r].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // one clock edge with credit bookkeeping, in_credit sampled before the edge updates
    task automatic tick();
        @(posedge clk);
        if (in_credit && credits >= `INST_Q_DEPTH) begin
            report_failure("in_credit pulsed while the sender already held every credit");
        end else if (in_credit) begin
            credits++;
            credit_pulses++;
        end
        in_valid <= 1'b0;
    endtask

    initial begin
        int gap;
        int waited;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_inst       = '0;
        credits       = `INST_Q_DEPTH;
        credit_pulses = 0;
        void'($urandom(32'h0190_03e7));
        build_table();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        foreach (prog_inst[i]) begin
            gap = ($urandom % 4 == 0) ? $urandom_range(3, 1) : 0;
            repeat (gap) tick();
            waited = 0;
            tick();
            while (credits == 0) begin
                if (waited >= TIMEOUT) begin
                    report_failure($sformatf("no credit came back while instruction %0d waited",
                                             i));
                end else begin
                    waited++;
                    tick();
                end
            end
            in_valid <= 1'b1;
            in_inst  <= prog_inst[i];
            credits--;
        end

        waited = 0;
        tick();
        while (!queues_empty()) begin
            if (waited >= TIMEOUT) begin
                report_failure("results still missing after the last instruction");
            end else begin
                waited++;
                tick();
            end
        end
        // quiet period to catch stray write-backs and late credits
        repeat (10) tick();
        check_value("in_credit pulse count", 32'(credit_pulses), 32'(prog_inst.size()));
        $display("RESULT: PASS");
        $finish;
    end

    always @(posedge clk) begin
        logic [31:0] exp_data;
        if (rst_n && wb_valid) begin
            if (wb_rd == '0) begin
                report_failure("wb_valid raised for a write to x0");
            end else if (exp_q[wb_rd].size() == 0) begin
                report_failure($sformatf("write-back to x%0d with no result expected", wb_rd));
            end else begin
                exp_data = exp_q[wb_rd].pop_front();
                check_value($sformatf("wb_data (x%0d)", wb_rd), wb_data, exp_data);
            end
        end
    end

endmodule

//--- exec_core.sv
`include "core_defs.svh"

module exec_core import stage_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  logic [`LEN_INST-1:0]     in_inst,
    output logic                     in_credit,
    output logic                     wb_valid,
    output logic [`LEN_REG_ADDR-1:0] wb_rd,
    output logic [`LEN_WORD-1:0]     wb_data
);
    dispatch_if dsp ();
    wb_if       wb ();

    inst_d_r_t inst_d_r;

    inst_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_inst   (in_inst),
        .in_credit (in_credit),
        .dsp       (dsp.decoder)
    );

    reg_manage u_reg_manage (
        .clk      (clk),
        .rst_n    (rst_n),
        .dsp      (dsp.regs),
        .wb       (wb.regs),
        .inst_d_r (inst_d_r)
    );

    inst_window u_inst_window (
        .clk      (clk),
        .rst_n    (rst_n),
        .dsp      (dsp.window),
        .inst_d_r (inst_d_r),
        .wb       (wb.window)
    );

    alu_exec u_alu_exec (
        .clk   (clk),
        .rst_n (rst_n),
        .wb    (wb.exec)
    );

    // result port is always accepted
    assign wb_valid = wb.wd.order;
    assign wb_rd    = wb.wd.va_rd;
    assign wb_data  = wb.wd.d_rd;

endmodule

//--- alu_exec.sv
`include "core_defs.svh"

module alu_exec import isa_pkg::*, stage_pkg::*; (
    input logic clk,
    input logic rst_n,
    wb_if.exec  wb
);
    localparam int SHAMT_W = $clog2(`LEN_WORD);

    logic                     s1_valid;
    exec_info_t               s1;
    logic [SHAMT_W-1:0]       shamt;
    logic [`LEN_WORD-1:0]     result;
    logic                     s2_order;
    logic [`LEN_REG_ADDR-1:0] s2_rd;
    logic [`LEN_WORD-1:0]     s2_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= wb.issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1 <= wb.issue;
    end

    assign shamt = s1.d_rs2[SHAMT_W-1:0];

    always_comb begin
        case (s1.alu_op)
            ALU_ADD:  result = s1.d_rs1 + s1.d_rs2;
            ALU_SUB:  result = s1.d_rs1 - s1.d_rs2;
            ALU_SLL:  result = s1.d_rs1 << shamt;
            ALU_SLT:  result = {{(`LEN_WORD-1){1'b0}}, $signed(s1.d_rs1) < $signed(s1.d_rs2)};
            ALU_SLTU: result = {{(`LEN_WORD-1){1'b0}}, s1.d_rs1 < s1.d_rs2};
            ALU_XOR:  result = s1.d_rs1 ^ s1.d_rs2;
            ALU_SRL:  result = s1.d_rs1 >> shamt;
            ALU_SRA:  result = $unsigned($signed(s1.d_rs1) >>> shamt);
            ALU_OR:   result = s1.d_rs1 | s1.d_rs2;
            ALU_AND:  result = s1.d_rs1 & s1.d_rs2;
            default:  result = s1.d_rs2;
        endcase
    end

    // x0 destinations execute but never broadcast
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_order <= 1'b0;
        end else begin
            s2_order <= s1_valid && s1.va_rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        s2_rd   <= s1.va_rd;
        s2_data <= result;
    end

    assign wb.wd = '{order: s2_order, va_rd: s2_rd, d_rd: s2_data};

endmodule

//--- inst_window.sv
`include "core_defs.svh"

module inst_window import stage_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    dispatch_if.window dsp,
    input  inst_d_r_t  inst_d_r,
    wb_if.window       wb
);
    logic [`WIN_DEPTH-1:0] valid;
    logic [`WIN_DEPTH-1:0] n_valid;
    logic [`WIN_DEPTH-1:0] ready;
    dec_exec_info_t        info   [`WIN_DEPTH];
    dec_exec_info_t        n_info [`WIN_DEPTH];
    inst_d_r_t             opr    [`WIN_DEPTH];
    inst_d_r_t             n_opr  [`WIN_DEPTH];
    logic                  issue_hit;
    logic [`WIN_IDX-1:0]   sel;
    logic                  dispatch;

    assign dispatch     = dsp.valid && !dsp.stall;
    assign dsp.win_full = &valid;

    // index 0 is the oldest, so scan downwards and keep the last hit
    always_comb begin
        issue_hit = 1'b0;
        sel       = '0;
        for (int i = `WIN_DEPTH - 1; i >= 0; i--) begin
            ready[i] = valid[i] && opr[i].rs1_ready && opr[i].rs2_ready;
            if (ready[i]) begin
                issue_hit = 1'b1;
                sel       = `WIN_IDX'(i);
            end
        end
    end

    assign wb.issue_valid = issue_hit;
    assign wb.issue = '{alu_op: info[sel].alu_op,
                        va_rd:  info[sel].inst_vreg.va_rd,
                        d_rs1:  opr[sel].d_rs1,
                        d_rs2:  opr[sel].d_rs2};

    always_comb begin
        int   src;
        logic placed;
        placed = 1'b0;
        for (int i = 0; i < `WIN_DEPTH; i++) begin
            // entries behind the issued one move up a slot
            src = (issue_hit && i >= int'(sel)) ? i + 1 : i;
            if (src < `WIN_DEPTH) begin
                n_valid[i] = valid[src];
                n_info[i]  = info[src];
                n_opr[i]   = opr[src];
            end else begin
                n_valid[i] = 1'b0;
                n_info[i]  = info[i];
                n_opr[i]   = opr[i];
            end
            // operand wakeup
            if (wb.wd.order && !n_opr[i].rs1_ready
                && n_info[i].inst_vreg.va_rs1 == wb.wd.va_rd) begin
                n_opr[i].rs1_ready = 1'b1;
                n_opr[i].d_rs1     = wb.wd.d_rd;
            end
            if (wb.wd.order && !n_opr[i].rs2_ready
                && n_info[i].inst_vreg.va_rs2 == wb.wd.va_rd) begin
                n_opr[i].rs2_ready = 1'b1;
                n_opr[i].d_rs2     = wb.wd.d_rd;
            end
            // new entry lands in the first free slot, already bypassed upstream
            if (dispatch && !n_valid[i] && !placed) begin
                n_valid[i] = 1'b1;
                n_info[i]  = dsp.info;
                n_opr[i]   = inst_d_r;
                placed     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            valid <= n_valid;
        end
    end

    always_ff @(posedge clk) begin
        info <= n_info;
        opr  <= n_opr;
    end

    // every dispatch lands in a free slot
    a_no_dsp_full: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch |=> $countones(valid)
                     == $past($countones(valid)) + 1 - $past(int'(issue_hit)));

endmodule

//--- reg_manage.sv
`include "core_defs.svh"

module reg_manage import stage_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    dispatch_if.regs  dsp,
    wb_if.regs        wb,
    output inst_d_r_t inst_d_r
);
    localparam int NUM_REGS = 2 ** `LEN_REG_ADDR;

    logic [`LEN_WORD-1:0] regs [NUM_REGS];
    logic [NUM_REGS-1:0]  busy;
    inst_vreg_t           vreg;
    logic                 wb_wr;
    logic                 dispatch;
    logic [`LEN_WORD:0]   opr1;
    logic [`LEN_WORD:0]   opr2;

    assign vreg     = dsp.info.inst_vreg;
    assign wb_wr    = wb.wd.order;
    assign dispatch = dsp.valid && !dsp.stall;

    // ready bit and value of one source, unused fields and x0 read as ready zero
    function automatic logic [`LEN_WORD:0] read_opr(
        input logic                     used,
        input logic [`LEN_REG_ADDR-1:0] addr
    );
        if (!used || addr == '0) begin
            return {1'b1, {`LEN_WORD{1'b0}}};
        end
        // same-cycle write-back bypass
        if (wb_wr && wb.wd.va_rd == addr) begin
            return {1'b1, wb.wd.d_rd};
        end
        return {!busy[addr], regs[addr]};
    endfunction

    always_comb begin
        opr1 = read_opr(vreg.rs1_order, vreg.va_rs1);
        opr2 = read_opr(vreg.rs2_order, vreg.va_rs2);
    end

    // a release on this cycle already frees the destination
    assign dsp.rd_busy = vreg.rd_order && vreg.va_rd != '0 && busy[vreg.va_rd]
                         && !(wb_wr && wb.wd.va_rd == vreg.va_rd);

    assign inst_d_r.rs1_ready = opr1[`LEN_WORD];
    assign inst_d_r.d_rs1     = opr1[`LEN_WORD-1:0];
    assign inst_d_r.rs2_ready = opr2[`LEN_WORD];
    assign inst_d_r.d_rs2     = dsp.info.use_imm ? dsp.info.d_imm : opr2[`LEN_WORD-1:0];
    assign inst_d_r.rd_ready  = !dsp.rd_busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (wb_wr) begin
                busy[wb.wd.va_rd] <= 1'b0;
            end
            // set wins over a same-cycle release of the same register
            if (dispatch && vreg.rd_order && vreg.va_rd != '0) begin
                busy[vreg.va_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_wr) begin
            regs[wb.wd.va_rd] <= wb.wd.d_rd;
        end
    end

    a_wb_to_busy: assert property (@(posedge clk) disable iff (!rst_n)
        wb_wr |-> busy[wb.wd.va_rd]);

endmodule

//--- inst_decoder.sv
`include "core_defs.svh"

module inst_decoder import isa_pkg::*, stage_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic [`LEN_INST-1:0] in_inst,
    output logic                 in_credit,
    dispatch_if.decoder          dsp
);
    localparam int PTR_W = $clog2(`INST_Q_DEPTH);

    logic [`LEN_INST-1:0] q_mem [`INST_Q_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W:0]       count;
    logic [`LEN_INST-1:0] head;
    logic                 pop;
    opcode_e              opcode;
    logic [2:0]           funct3;
    dec_exec_info_t       dec;

    assign head   = q_mem[rd_ptr];
    assign opcode = opcode_e'(head[6:0]);
    assign funct3 = head[14:12];

    assign dsp.valid = (count != '0);
    assign dsp.info  = dec;
    assign pop       = dsp.valid && !dsp.stall;

    always_ff @(posedge clk) begin
        if (in_valid) begin
            q_mem[wr_ptr] <= in_inst;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // slot freed by the dispatch goes back to the sender
            in_credit <= pop;
        end
    end

    always_comb begin
        dec = '0;
        dec.inst_vreg.va_rs1 = head[19:15];
        dec.inst_vreg.va_rs2 = head[24:20];
        dec.inst_vreg.va_rd  = head[11:7];
        case (funct3)
            3'b000:  dec.alu_op = (opcode == OPC_OP && head[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  dec.alu_op = ALU_SLL;
            3'b010:  dec.alu_op = ALU_SLT;
            3'b011:  dec.alu_op = ALU_SLTU;
            3'b100:  dec.alu_op = ALU_XOR;
            // srai keeps bit 30 in its immediate field
            3'b101:  dec.alu_op = head[30] ? ALU_SRA : ALU_SRL;
            3'b110:  dec.alu_op = ALU_OR;
            default: dec.alu_op = ALU_AND;
        endcase
        case (opcode)
            OPC_OP: begin
                dec.inst_vreg.rs1_order = 1'b1;
                dec.inst_vreg.rs2_order = 1'b1;
                dec.inst_vreg.rd_order  = 1'b1;
            end
            OPC_OP_IMM: begin
                dec.inst_vreg.rs1_order = 1'b1;
                dec.inst_vreg.rd_order  = 1'b1;
                dec.d_imm   = {{(`LEN_WORD-12){head[31]}}, head[31:20]};
                dec.use_imm = 1'b1;
            end
            OPC_LUI: begin
                dec.inst_vreg.rd_order = 1'b1;
                dec.alu_op  = ALU_PASS_B;
                dec.d_imm   = {head[31:12], 12'b0};
                dec.use_imm = 1'b1;
            end
            default: dec.alu_op = ALU_PASS_B;
        endcase
    end

    // the sender only pushes while it holds a credit
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> count != `INST_Q_DEPTH);

    a_known_opcode: assert property (@(posedge clk) disable iff (!rst_n)
        dsp.valid |-> opcode inside {OPC_OP, OPC_OP_IMM, OPC_LUI});

endmodule

//--- stage_if.sv
interface dispatch_if import stage_pkg::*; ();
    logic           valid;
    logic           stall;
    logic           rd_busy;
    logic           win_full;
    dec_exec_info_t info;

    // either side can hold the queue head
    assign stall = rd_busy | win_full;

    modport decoder (
        output valid, info,
        input  stall
    );
    modport regs (
        input  valid, info, stall,
        output rd_busy
    );
    modport window (
        input  valid, info, stall,
        output win_full
    );
endinterface

interface wb_if import stage_pkg::*; ();
    logic       issue_valid;
    exec_info_t issue;
    write_d_r_t wd;

    modport exec (
        input  issue_valid, issue,
        output wd
    );
    modport window (
        output issue_valid, issue,
        input  wd
    );
    modport regs (
        input  wd
    );
endinterface

//--- stage_pkg.sv
`include "core_defs.svh"

package stage_pkg;
    import isa_pkg::*;

    // register fields of one instruction, order bit marks a used field
    typedef struct packed {
        logic                     rs1_order;
        logic [`LEN_REG_ADDR-1:0] va_rs1;
        logic                     rs2_order;
        logic [`LEN_REG_ADDR-1:0] va_rs2;
        logic                     rd_order;
        logic [`LEN_REG_ADDR-1:0] va_rd;
    } inst_vreg_t;

    // decoder to window
    typedef struct packed {
        alu_op_e              alu_op;
        inst_vreg_t           inst_vreg;
        logic [`LEN_WORD-1:0] d_imm;
        logic                 use_imm;
    } dec_exec_info_t;

    // register manager to window
    typedef struct packed {
        logic                 rs1_ready;
        logic [`LEN_WORD-1:0] d_rs1;
        logic                 rs2_ready;
        logic [`LEN_WORD-1:0] d_rs2;
        logic                 rd_ready;
    } inst_d_r_t;

    // window to ALU, d_rs2 already carries the immediate
    typedef struct packed {
        alu_op_e                  alu_op;
        logic [`LEN_REG_ADDR-1:0] va_rd;
        logic [`LEN_WORD-1:0]     d_rs1;
        logic [`LEN_WORD-1:0]     d_rs2;
    } exec_info_t;

    // write-back broadcast
    typedef struct packed {
        logic                     order;
        logic [`LEN_REG_ADDR-1:0] va_rd;
        logic [`LEN_WORD-1:0]     d_rd;
    } write_d_r_t;

endpackage

//--- isa_pkg.sv
package isa_pkg;

    // major opcodes handled by this slice
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        // lui result is the immediate itself
        ALU_PASS_B = 4'd10
    } alu_op_e;

endpackage

//--- core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath widths
`define LEN_WORD     32
`define LEN_INST     32
`define LEN_REG_ADDR 5

// instruction window
`define WIN_DEPTH    4
`define WIN_IDX      2

// input queue depth, also the credits held by the sender after reset
`define INST_Q_DEPTH 4

`endif
